//--- common/dac_pkg.sv
package dac_pkg;

  // sample format of the DAC datapath
  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 16;

  // signed fixed point scale with 2 integer bits and 16 fractional bits
  localparam int SCALE_WIDTH = 18;
  localparam int SCALE_FRAC_BITS = 16;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [SCALE_WIDTH-1:0] scale_t;

  // one beat of parallel samples with lane 0 in the low bits
  typedef struct packed {
    sample_t [PARALLEL_SAMPLES-1:0] samples;
  } sample_beat_t;

  // four-phase load request toward the scale loader
  typedef struct packed {
    logic req;
    scale_t scale;
  } scale_load_t;

endpackage

//--- rtl/scale_loader.sv
`timescale 1ns/1ns

// four-phase req/ack responder holding the active scale factor
module scale_loader (
  input  logic                clk,
  input  logic                reset,
  input  dac_pkg::scale_load_t load,
  output logic                load_ack,
  output dac_pkg::scale_t     active_scale
);

  // unity gain in the scale's fixed point format
  localparam dac_pkg::scale_t SCALE_ONE = dac_pkg::scale_t'(1 << dac_pkg::SCALE_FRAC_BITS);

  typedef enum logic {
    st_idle,
    st_ack
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      active_scale <= SCALE_ONE;
    end else begin
      case (state)
        st_idle: begin
          // capture on the rising phase only
          if (load.req) begin
            active_scale <= load.scale;
            state <= st_ack;
          end
        end
        st_ack: begin
          // hold ack until the sender has released req
          if (!load.req) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ack is the state bit itself and comes straight from a flop
  assign load_ack = (state == st_ack);

endmodule

//--- dac_prescaler/dac_prescaler.sv
`timescale 1ns/1ns

// multiply each lane by the scale, round half up and saturate to the sample range
module dac_prescaler #(
  parameter int PIPE_STAGES = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  dac_pkg::sample_beat_t in_beat,
  input  dac_pkg::scale_t       active_scale,
  output logic                  pipe_valid,
  output dac_pkg::sample_beat_t pipe_beat,
  input  logic                  buf_ready
);

  localparam int PROD_WIDTH = dac_pkg::SAMPLE_WIDTH + dac_pkg::SCALE_WIDTH;
  localparam int SHIFT_WIDTH = PROD_WIDTH - dac_pkg::SCALE_FRAC_BITS;
  localparam logic signed [PROD_WIDTH-1:0] ROUND_HALF =
    PROD_WIDTH'(2 ** (dac_pkg::SCALE_FRAC_BITS - 1));
  localparam int SAT_MAX = 2 ** (dac_pkg::SAMPLE_WIDTH - 1) - 1;
  localparam int SAT_MIN = -(2 ** (dac_pkg::SAMPLE_WIDTH - 1));

  typedef logic signed [PROD_WIDTH-1:0] prod_t;
  typedef prod_t [dac_pkg::PARALLEL_SAMPLES-1:0] prod_lanes_t;

  logic                  advance;
  logic                  front_valid;
  dac_pkg::sample_beat_t front_beat;
  dac_pkg::scale_t       front_scale;
  prod_lanes_t           front_prods;
  logic                  last_in_valid;
  prod_lanes_t           last_in_prods;
  dac_pkg::sample_beat_t sat_beat;

  // the whole pipe moves together whenever the last stage is free or empty
  assign advance = buf_ready || !pipe_valid;
  assign in_ready = advance;

  generate
    if (PIPE_STAGES < 1 || PIPE_STAGES > 3) begin : g_bad_depth
      $error("dac_prescaler supports 1 to 3 pipeline stages");
    end

    if (PIPE_STAGES == 1) begin : g_direct
      // single stage multiplies straight from the input
      assign front_valid = in_valid;
      assign front_beat = in_beat;
      assign front_scale = active_scale;
    end else begin : g_input_reg
      logic                  s1_valid;
      dac_pkg::sample_beat_t s1_beat;
      dac_pkg::scale_t       s1_scale;

      always_ff @(posedge clk) begin
        if (reset) begin
          s1_valid <= 1'b0;
        end else if (advance) begin
          s1_valid <= in_valid;
        end
      end

      // scale rides along with its beat
      always_ff @(posedge clk) begin
        if (advance) begin
          s1_beat <= in_beat;
          s1_scale <= active_scale;
        end
      end

      assign front_valid = s1_valid;
      assign front_beat = s1_beat;
      assign front_scale = s1_scale;
    end
  endgenerate

  // one full width signed product per lane
  always_comb begin
    for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
      front_prods[l] = front_beat.samples[l] * front_scale;
    end
  end

  generate
    if (PIPE_STAGES == 3) begin : g_mid_reg
      logic        mid_valid;
      prod_lanes_t mid_prods;

      always_ff @(posedge clk) begin
        if (reset) begin
          mid_valid <= 1'b0;
        end else if (advance) begin
          mid_valid <= front_valid;
        end
      end

      always_ff @(posedge clk) begin
        if (advance) begin
          mid_prods <= front_prods;
        end
      end

      assign last_in_valid = mid_valid;
      assign last_in_prods = mid_prods;
    end else begin : g_mid_bypass
      assign last_in_valid = front_valid;
      assign last_in_prods = front_prods;
    end
  endgenerate

  // round half up, drop the fraction, clamp to the sample range
  always_comb begin
    prod_t                          rounded;
    logic signed [SHIFT_WIDTH-1:0]  shifted;
    for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
      rounded = last_in_prods[l] + ROUND_HALF;
      shifted = rounded[PROD_WIDTH-1:dac_pkg::SCALE_FRAC_BITS];
      if (shifted > SAT_MAX) begin
        sat_beat.samples[l] = dac_pkg::sample_t'(SAT_MAX);
      end else if (shifted < SAT_MIN) begin
        sat_beat.samples[l] = dac_pkg::sample_t'(SAT_MIN);
      end else begin
        sat_beat.samples[l] = shifted[dac_pkg::SAMPLE_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_valid <= 1'b0;
    end else if (advance) begin
      pipe_valid <= last_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      pipe_beat <= sat_beat;
    end
  end

endmodule

//--- dac_prescaler/beat_skid_buffer.sv
`timescale 1ns/1ns

// two-entry buffer made of an output register plus one skid entry
module beat_skid_buffer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  dac_pkg::sample_beat_t in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output dac_pkg::sample_beat_t out_beat
);

  logic                  skid_valid;
  dac_pkg::sample_beat_t skid_beat;
  logic                  push;
  logic                  out_free;

  // ready depends only on the skid flop and never on out_ready
  assign in_ready = !skid_valid;
  assign push = in_valid && in_ready;
  // output register empties or is read this cycle
  assign out_free = out_ready || !out_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // the older skid entry drains first
      if (skid_valid) begin
        out_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= push;
      end
    end else if (push) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        out_beat <= skid_beat;
      end else if (push) begin
        out_beat <= in_beat;
      end
    end
  end

  // park the incoming beat while the output is stalled
  always_ff @(posedge clk) begin
    if (push && !out_free) begin
      skid_beat <= in_beat;
    end
  end

endmodule

//--- rtl/dac_scale_top.sv
`timescale 1ns/1ns

// DAC sample prescaler with a four-phase scale load port
module dac_scale_top (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  dac_pkg::sample_beat_t in_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output dac_pkg::sample_beat_t out_beat,
  input  dac_pkg::scale_load_t  load,
  output logic                  load_ack
);

  localparam int PIPE_STAGES = 2;

  dac_pkg::scale_t       active_scale;
  logic                  pipe_valid;
  dac_pkg::sample_beat_t pipe_beat;
  logic                  buf_ready;

  scale_loader scale_loader_i (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .load_ack     (load_ack),
    .active_scale (active_scale)
  );

  dac_prescaler #(
    .PIPE_STAGES (PIPE_STAGES)
  ) dac_prescaler_i (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_beat      (in_beat),
    .active_scale (active_scale),
    .pipe_valid   (pipe_valid),
    .pipe_beat    (pipe_beat),
    .buf_ready    (buf_ready)
  );

  // output buffer adds one cycle of latency
  beat_skid_buffer beat_skid_buffer_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (pipe_valid),
    .in_ready  (buf_ready),
    .in_beat   (pipe_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

endmodule

//--- dv/dac_scale_checker.sv
`timescale 1ns/1ns

// handshake assertions bound into the top level
module dac_scale_checker (
  input logic                  clk,
  input logic                  reset,
  input dac_pkg::scale_load_t  load,
  input logic                  load_ack,
  input logic                  out_valid,
  input logic                  out_ready,
  input dac_pkg::sample_beat_t out_beat
);

  // a new request may only start once ack has dropped
  load_handshake_a: assert property (@(posedge clk) disable iff (reset)
    load_ack |-> !$rose(load.req))
    else $error("load.req rose while load_ack was high");

  // a stalled output beat has to hold until it is taken
  out_stable_a: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("out_beat changed while the output was stalled");

  // nothing leaves the buffer while in reset
  reset_idle_a: assert property (@(posedge clk)
    reset |=> !out_valid)
    else $error("out_valid was high during reset");

endmodule

bind dac_scale_top dac_scale_checker checker_i (
  .clk       (clk),
  .reset     (reset),
  .load      (load),
  .load_ack  (load_ack),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_beat  (out_beat)
);

//--- dv/dac_scale_tb.sv
`timescale 1ns/1ns

module dac_scale_tb;

  localparam int TIMEOUT = 200;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  in_valid;
  logic                  in_ready;
  dac_pkg::sample_beat_t in_beat;
  logic                  out_valid;
  logic                  out_ready = 1'b1;
  dac_pkg::sample_beat_t out_beat;
  dac_pkg::scale_load_t  load;
  logic                  load_ack;

  logic                  random_ready = 1'b0;
  dac_pkg::scale_t       model_scale;
  dac_pkg::sample_beat_t exp_q[$];
  int mismatch_count = 0;
  int failure_count = 0;
  int in_count = 0;
  int out_count = 0;
  int cycle = 0;
  int first_in_cycle = -1;
  int first_out_cycle = -1;

  dac_scale_top dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat),
    .load      (load),
    .load_ack  (load_ack)
  );

  always #5 clk = ~clk;

  // sink side back-pressure
  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      out_ready = 1'($urandom_range(0, 1));
    end else begin
      out_ready = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h", name, actual, expected);
      mismatch_count++;
    end
  endtask

  // reference lane model adds half an lsb to the product, shifts and clamps
  function automatic dac_pkg::sample_t model_lane(input dac_pkg::sample_t s,
                                                  input dac_pkg::scale_t k);
    longint p;
    p = longint'(s) * longint'(k);
    p = (p + (longint'(1) <<< (dac_pkg::SCALE_FRAC_BITS - 1))) >>> dac_pkg::SCALE_FRAC_BITS;
    if (p > 32767) begin
      p = 32767;
    end else if (p < -32768) begin
      p = -32768;
    end
    return dac_pkg::sample_t'(p);
  endfunction

  function automatic dac_pkg::sample_beat_t model_beat(input dac_pkg::sample_beat_t b,
                                                       input dac_pkg::scale_t k);
    dac_pkg::sample_beat_t r;
    for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
      r.samples[l] = model_lane(b.samples[l], k);
    end
    return r;
  endfunction

  function automatic dac_pkg::sample_beat_t random_beat();
    dac_pkg::sample_beat_t b;
    for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
      b.samples[l] = dac_pkg::sample_t'($urandom);
    end
    return b;
  endfunction

  // full scale and near full scale lanes to push the clamp
  function automatic dac_pkg::sample_beat_t extreme_beat();
    dac_pkg::sample_beat_t b;
    for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
      case ($urandom_range(0, 3))
        0: b.samples[l] = dac_pkg::sample_t'(-32768);
        1: b.samples[l] = dac_pkg::sample_t'(32767);
        2: b.samples[l] = dac_pkg::sample_t'(-32767);
        default: b.samples[l] = dac_pkg::sample_t'($urandom);
      endcase
    end
    return b;
  endfunction

  // transfers are sampled at the falling edge where both sides are settled
  always @(negedge clk) begin : monitor
    dac_pkg::sample_beat_t exp_beat;
    cycle++;
    if (!reset && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("an output beat arrived while no beat was expected");
        failure_count++;
      end else begin
        exp_beat = exp_q.pop_front();
        for (int l = 0; l < dac_pkg::PARALLEL_SAMPLES; l++) begin
          check_value($sformatf("out_beat.samples[%0d]", l), 32'(out_beat.samples[l]),
                      32'(exp_beat.samples[l]));
        end
      end
      out_count++;
      if (first_out_cycle < 0) first_out_cycle = cycle;
    end
    if (!reset && in_valid && in_ready) begin
      exp_q.push_back(model_beat(in_beat, model_scale));
      in_count++;
      if (first_in_cycle < 0) first_in_cycle = cycle;
    end
  end

  // called just after a rising edge and returns just after the transfer edge
  task automatic send_beat(input dac_pkg::sample_beat_t beat);
    int waited;
    in_valid = 1'b1;
    in_beat = beat;
    waited = 0;
    @(negedge clk);
    while (!in_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("timed out waiting for in_ready");
      failure_count++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic load_scale(input dac_pkg::scale_t scale);
    int edges;
    in_valid = 1'b0;
    check_value("load_ack", load_ack, 0);
    load.scale = scale;
    load.req = 1'b1;
    edges = 0;
    while (!load_ack && edges < TIMEOUT) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (!load_ack) begin
      $display("timed out waiting for load_ack to rise");
      failure_count++;
    end else begin
      check_value("load_ack rise edges", edges, 1);
    end
    model_scale = scale;
    // scale changes while ack is high must be ignored
    load.req = 1'b0;
    load.scale = dac_pkg::scale_t'($urandom);
    edges = 0;
    while (load_ack && edges < TIMEOUT) begin
      @(posedge clk);
      #1;
      edges++;
    end
    if (load_ack) begin
      $display("timed out waiting for load_ack to fall");
      failure_count++;
    end else begin
      check_value("load_ack fall edges", edges, 1);
    end
  endtask

  task automatic drain();
    int waited;
    in_valid = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out waiting for the expected output beats to drain");
      failure_count++;
    end
  endtask

  initial begin
    void'($urandom(41086));
    reset = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    load = '0;
    model_scale = dac_pkg::scale_t'(1 << dac_pkg::SCALE_FRAC_BITS);
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    check_value("in_ready", in_ready, 1);
    check_value("out_valid", out_valid, 0);
    check_value("load_ack", load_ack, 0);

    // unity scale passes samples through
    for (int i = 0; i < 20; i++) send_beat(random_beat());
    drain();
    check_value("first output latency", first_out_cycle - first_in_cycle, 3);

    for (int i = 0; i < 6; i++) begin
      load_scale(dac_pkg::scale_t'($urandom));
      for (int j = 0; j < 10; j++) send_beat(random_beat());
    end

    // scales close to plus and minus 2.0
    load_scale(dac_pkg::scale_t'(131071));
    for (int j = 0; j < 8; j++) send_beat(extreme_beat());
    load_scale(dac_pkg::scale_t'(-131072));
    for (int j = 0; j < 8; j++) send_beat(extreme_beat());
    load_scale(dac_pkg::scale_t'(-129000));
    for (int j = 0; j < 8; j++) send_beat(extreme_beat());
    drain();

    // continuous input against a random sink
    load_scale(dac_pkg::scale_t'(49152));
    random_ready = 1'b1;
    for (int i = 0; i < 60; i++) send_beat(random_beat());
    drain();
    check_value("queue size", exp_q.size(), 0);

    // random gaps with some loads back to back
    for (int b = 0; b < 5; b++) begin
      load_scale(dac_pkg::scale_t'($urandom));
      if (b % 2 == 0) load_scale(dac_pkg::scale_t'($urandom));
      for (int j = 0; j < 30; j++) begin
        in_valid = 1'b0;
        repeat ($urandom_range(0, 2)) begin
          @(posedge clk);
          #1;
        end
        send_beat(random_beat());
      end
    end
    drain();
    check_value("beat count", out_count, in_count);
    check_value("queue size", exp_q.size(), 0);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- dac_scale_top.f
common/dac_pkg.sv
rtl/scale_loader.sv
dac_prescaler/dac_prescaler.sv
dac_prescaler/beat_skid_buffer.sv
rtl/dac_scale_top.sv
dv/dac_scale_checker.sv
dv/dac_scale_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DAC prescaler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dac_scale_tb \
  -f dac_scale_top.f -o dac_scale_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/dac_scale_sim > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
